//--- verilog/pad_shell_config.svh
/*
  Pad counts, widths and pad indices for the simulation pad shell.
  Include wherever a pad vector is sized or a pad is picked by index.
*/
`ifndef PAD_SHELL_CONFIG_SVH
`define PAD_SHELL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// counts and widths
////////////////////////////////////////////////////////////////////////////

// multiplexed and dedicated pads on the core side
`define NUM_MIO_PADS 47
`define NUM_DIO_PADS 16

// chip gpio pins
`define GPIO_WIDTH 32

// pull_select and pull_en per pad
`define PAD_ATTR_WIDTH 2

// fake supply counter, saturates at all ones
`define SUPPLY_CNT_WIDTH 4

////////////////////////////////////////////////////////////////////////////
// mio pad indices
////////////////////////////////////////////////////////////////////////////

// Iob6..Iob12 occupy 15..21
`define MIO_IOB6 15
// Ioc0..Ioc2 occupy 22..24, the sw straps
`define MIO_IOC0 22
`define MIO_IOC3 25
`define MIO_IOC4 26
`define MIO_IOC5 27
`define MIO_IOC7 29
`define MIO_IOC8 30
// Ior5..Ior7 then Ior10..Ior13 occupy 40..46
`define MIO_IOR5 40

// dio pad indices
`define DIO_USB_DP  0
`define DIO_USB_DN  1
`define DIO_SPI_SCK 2
`define DIO_SPI_CSB 3
`define DIO_SPI_SD0 4
`define DIO_SPI_SD1 5

`endif

//--- verilog/pad_shell_pkg.sv
/*
  Shared types for the pad shell: pad vectors and the pad attribute word.
*/
`include "pad_shell_config.svh"

package pad_shell_pkg;

  // one bit per multiplexed pad
  typedef logic [`NUM_MIO_PADS-1:0] mio_vec_t;

  // one bit per dedicated pad
  typedef logic [`NUM_DIO_PADS-1:0] dio_vec_t;

  // one bit per chip gpio pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

  // attribute word as the core sends it, or split into its pull fields
  typedef union packed {
    logic [`PAD_ATTR_WIDTH-1:0] raw;
    struct packed {
      logic pull_select;
      logic pull_en;
    } fields;
  } pad_attr_u;

endpackage

//--- verilog/pad_core_if.sv
/*
  Core-side pad vectors shared between the shell top and the two mapping blocks.
  in_side fills the input vectors, out_side reads outputs, enables and attributes.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

interface pad_core_if;

  // pad to core
  pad_shell_pkg::mio_vec_t mio_in;
  pad_shell_pkg::dio_vec_t dio_in;

  // core to pad
  pad_shell_pkg::mio_vec_t mio_out;
  pad_shell_pkg::mio_vec_t mio_oe;
  pad_shell_pkg::pad_attr_u [`NUM_MIO_PADS-1:0] mio_attr;
  pad_shell_pkg::dio_vec_t dio_out;
  pad_shell_pkg::dio_vec_t dio_oe;

  modport in_side (
    output mio_in,
    output dio_in
  );

  modport out_side (
    input mio_out,
    input mio_oe,
    input mio_attr,
    input dio_out,
    input dio_oe
  );

endinterface

//--- verilog/pad_in_map.sv
/*
  Places chip input pins onto the core's MIO and DIO input vectors.
  Purely combinational, pads without a pin read as zero.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

module pad_in_map (
  pad_core_if.in_side              core,
  input pad_shell_pkg::gpio_vec_t  gpio_p2d_i,
  input logic                      uart_rx_p2d_i,
  input logic                      spi_sck_p2d_i,
  input logic                      spi_csb_p2d_i,
  input logic                      spi_sdi_p2d_i,
  input logic                      usb_sense_p2d_i,
  input logic                      usb_dp_p2d_i,
  input logic                      usb_dn_p2d_i
);

  pad_shell_pkg::mio_vec_t mio_vec;
  pad_shell_pkg::dio_vec_t dio_vec;

  always_comb begin : build_mio
    mio_vec = '0;
    // generic gpios, 7 on Iob6..12 and 7 on Ior5..13
    mio_vec[`MIO_IOB6 +: 7] = gpio_p2d_i[6:0];
    mio_vec[`MIO_IOR5 +: 7] = gpio_p2d_i[13:7];
    // sw straps
    mio_vec[`MIO_IOC0 +: 3] = gpio_p2d_i[24:22];
    // tap straps
    mio_vec[`MIO_IOC5] = gpio_p2d_i[27];
    mio_vec[`MIO_IOC8] = gpio_p2d_i[30];
    // uart rx and vbus sense
    mio_vec[`MIO_IOC3] = uart_rx_p2d_i;
    mio_vec[`MIO_IOC7] = usb_sense_p2d_i;
  end

  always_comb begin : build_dio
    dio_vec = '0;
    dio_vec[`DIO_SPI_SCK] = spi_sck_p2d_i;
    dio_vec[`DIO_SPI_CSB] = spi_csb_p2d_i;
    // host data in lands on sd0
    dio_vec[`DIO_SPI_SD0] = spi_sdi_p2d_i;
    dio_vec[`DIO_USB_DP]  = usb_dp_p2d_i;
    dio_vec[`DIO_USB_DN]  = usb_dn_p2d_i;
  end

  assign core.mio_in = mio_vec;
  assign core.dio_in = dio_vec;

endmodule

//--- verilog/pad_out_map.sv
/*
  Drives chip output pins, enables and gpio pull vectors from core pad outputs.
  Purely combinational, gpio bits without a pad stay at zero.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

module pad_out_map (
  pad_core_if.out_side              core,
  // gpio
  output pad_shell_pkg::gpio_vec_t  gpio_d2p_o,
  output pad_shell_pkg::gpio_vec_t  gpio_en_d2p_o,
  output pad_shell_pkg::gpio_vec_t  gpio_pull_en_o,
  output pad_shell_pkg::gpio_vec_t  gpio_pull_select_o,
  // uart
  output logic                      uart_tx_d2p_o,
  output logic                      uart_tx_en_d2p_o,
  // spi device
  output logic                      spi_sdo_d2p_o,
  output logic                      spi_sdo_en_d2p_o,
  // usb
  output logic                      usb_dp_d2p_o,
  output logic                      usb_dp_en_d2p_o,
  output logic                      usb_dn_d2p_o,
  output logic                      usb_dn_en_d2p_o,
  output logic                      usb_d_en_d2p_o
);

  ////////////////////////////////////////////////////////////////////////////
  // gpio order
  ////////////////////////////////////////////////////////////////////////////

  // same bit to pad order as the input map, unmapped bits are zero
  function automatic pad_shell_pkg::gpio_vec_t gpio_gather(
    input pad_shell_pkg::mio_vec_t pads
  );
    pad_shell_pkg::gpio_vec_t g;
    g = '0;
    // generic gpios
    g[6:0]   = pads[`MIO_IOB6 +: 7];
    g[13:7]  = pads[`MIO_IOR5 +: 7];
    // sw straps
    g[24:22] = pads[`MIO_IOC0 +: 3];
    // tap straps
    g[27]    = pads[`MIO_IOC5];
    g[30]    = pads[`MIO_IOC8];
    return g;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // pull attributes
  ////////////////////////////////////////////////////////////////////////////

  pad_shell_pkg::mio_vec_t pull_en_pads;
  pad_shell_pkg::mio_vec_t pull_sel_pads;

  // split each attribute word into its two pull bits
  always_comb begin : split_attr
    for (int i = 0; i < `NUM_MIO_PADS; i++) begin
      pull_en_pads[i]  = core.mio_attr[i].fields.pull_en;
      pull_sel_pads[i] = core.mio_attr[i].fields.pull_select;
    end
  end

  // pull vectors share the gpio order so a pin model can pair them with data
  assign gpio_pull_en_o     = gpio_gather(pull_en_pads);
  assign gpio_pull_select_o = gpio_gather(pull_sel_pads);

  // gpio data and enables
  assign gpio_d2p_o    = gpio_gather(core.mio_out);
  assign gpio_en_d2p_o = gpio_gather(core.mio_oe);

  ////////////////////////////////////////////////////////////////////////////
  // peripheral pins
  ////////////////////////////////////////////////////////////////////////////

  // uart tx on Ioc4
  assign uart_tx_d2p_o    = core.mio_out[`MIO_IOC4];
  assign uart_tx_en_d2p_o = core.mio_oe[`MIO_IOC4];

  // device data out leaves on sd1
  assign spi_sdo_d2p_o    = core.dio_out[`DIO_SPI_SD1];
  assign spi_sdo_en_d2p_o = core.dio_oe[`DIO_SPI_SD1];

  // usb differential pair
  assign usb_dp_d2p_o    = core.dio_out[`DIO_USB_DP];
  assign usb_dp_en_d2p_o = core.dio_oe[`DIO_USB_DP];
  assign usb_dn_d2p_o    = core.dio_out[`DIO_USB_DN];
  assign usb_dn_en_d2p_o = core.dio_oe[`DIO_USB_DN];

  // single-ended d output is enabled together with dp
  assign usb_d_en_d2p_o = core.dio_oe[`DIO_USB_DP];

endmodule

//--- verilog/por_supply_seq.sv
/*
  Fake supply ramp for simulation: a saturating counter whose value is decoded
  into a low, high, low, high power-ok pattern that serves as the chip POR.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

module por_supply_seq (
  input  logic clk_aon,
  input  logic rst_n_i,
  output logic por_n_o
);

  // phase boundaries of the pok pattern
  localparam logic [`SUPPLY_CNT_WIDTH-1:0] FIRST_RISE = `SUPPLY_CNT_WIDTH'(4);
  localparam logic [`SUPPLY_CNT_WIDTH-1:0] DIP_START  = `SUPPLY_CNT_WIDTH'(8);
  localparam logic [`SUPPLY_CNT_WIDTH-1:0] FINAL_RISE = `SUPPLY_CNT_WIDTH'(12);

  logic [`SUPPLY_CNT_WIDTH-1:0] supply_cnt;

  // count up once per edge and hold at all ones
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      supply_cnt <= '0;
    end else if (supply_cnt != '1) begin
      supply_cnt <= supply_cnt + 1'b1;
    end
  end

  // supply comes up, drops once, then stays up
  always_comb begin : decode_pok
    if (supply_cnt < FIRST_RISE) begin
      por_n_o = 1'b0;
    end else if (supply_cnt < DIP_START) begin
      por_n_o = 1'b1;
    end else if (supply_cnt < FINAL_RISE) begin
      por_n_o = 1'b0;
    end else begin
      por_n_o = 1'b1;
    end
  end

endmodule

//--- verilog/chip_pad_shell.sv
/*
  Pad shell of the simulation chip top. The core sits outside as plain ports;
  pins map to and from its MIO/DIO vectors and a fake POR is generated on clk_aon.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

module chip_pad_shell (
  input  logic                                        clk_aon,
  input  logic                                        rst_n_i,

  // gpio pins
  input  pad_shell_pkg::gpio_vec_t                    gpio_p2d_i,
  output pad_shell_pkg::gpio_vec_t                    gpio_d2p_o,
  output pad_shell_pkg::gpio_vec_t                    gpio_en_d2p_o,
  output pad_shell_pkg::gpio_vec_t                    gpio_pull_en_o,
  output pad_shell_pkg::gpio_vec_t                    gpio_pull_select_o,

  // uart pins
  input  logic                                        uart_rx_p2d_i,
  output logic                                        uart_tx_d2p_o,
  output logic                                        uart_tx_en_d2p_o,

  // spi device pins
  input  logic                                        spi_sck_p2d_i,
  input  logic                                        spi_csb_p2d_i,
  input  logic                                        spi_sdi_p2d_i,
  output logic                                        spi_sdo_d2p_o,
  output logic                                        spi_sdo_en_d2p_o,

  // usb pins
  input  logic                                        usb_sense_p2d_i,
  input  logic                                        usb_dp_p2d_i,
  input  logic                                        usb_dn_p2d_i,
  output logic                                        usb_dp_d2p_o,
  output logic                                        usb_dp_en_d2p_o,
  output logic                                        usb_dn_d2p_o,
  output logic                                        usb_dn_en_d2p_o,
  output logic                                        usb_d_en_d2p_o,

  // core side, multiplexed pads
  input  pad_shell_pkg::mio_vec_t                     mio_out_i,
  input  pad_shell_pkg::mio_vec_t                     mio_oe_i,
  input  logic [`NUM_MIO_PADS*`PAD_ATTR_WIDTH-1:0]    mio_attr_i,
  output pad_shell_pkg::mio_vec_t                     mio_in_o,

  // core side, dedicated pads
  input  pad_shell_pkg::dio_vec_t                     dio_out_i,
  input  pad_shell_pkg::dio_vec_t                     dio_oe_i,
  output pad_shell_pkg::dio_vec_t                     dio_in_o,

  // fake power-on reset
  output logic                                        por_n_o
);

  pad_core_if core ();

  ////////////////////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////////////////////

  assign core.mio_out = mio_out_i;
  assign core.mio_oe  = mio_oe_i;
  assign core.dio_out = dio_out_i;
  assign core.dio_oe  = dio_oe_i;

  // pad n arrives at bits 2n+1..2n as a raw word
  for (genvar p = 0; p < `NUM_MIO_PADS; p++) begin : g_attr
    assign core.mio_attr[p].raw = mio_attr_i[p*`PAD_ATTR_WIDTH +: `PAD_ATTR_WIDTH];
  end

  assign mio_in_o = core.mio_in;
  assign dio_in_o = core.dio_in;

  ////////////////////////////////////////////////////////////////////////////
  // pad mapping and supply sequence
  ////////////////////////////////////////////////////////////////////////////

  pad_in_map u_pad_in_map (
    .core            (core),
    .gpio_p2d_i      (gpio_p2d_i),
    .uart_rx_p2d_i   (uart_rx_p2d_i),
    .spi_sck_p2d_i   (spi_sck_p2d_i),
    .spi_csb_p2d_i   (spi_csb_p2d_i),
    .spi_sdi_p2d_i   (spi_sdi_p2d_i),
    .usb_sense_p2d_i (usb_sense_p2d_i),
    .usb_dp_p2d_i    (usb_dp_p2d_i),
    .usb_dn_p2d_i    (usb_dn_p2d_i)
  );

  pad_out_map u_pad_out_map (
    .core               (core),
    .gpio_d2p_o         (gpio_d2p_o),
    .gpio_en_d2p_o      (gpio_en_d2p_o),
    .gpio_pull_en_o     (gpio_pull_en_o),
    .gpio_pull_select_o (gpio_pull_select_o),
    .uart_tx_d2p_o      (uart_tx_d2p_o),
    .uart_tx_en_d2p_o   (uart_tx_en_d2p_o),
    .spi_sdo_d2p_o      (spi_sdo_d2p_o),
    .spi_sdo_en_d2p_o   (spi_sdo_en_d2p_o),
    .usb_dp_d2p_o       (usb_dp_d2p_o),
    .usb_dp_en_d2p_o    (usb_dp_en_d2p_o),
    .usb_dn_d2p_o       (usb_dn_d2p_o),
    .usb_dn_en_d2p_o    (usb_dn_en_d2p_o),
    .usb_d_en_d2p_o     (usb_d_en_d2p_o)
  );

  // stands in for the analog supply monitor
  por_supply_seq u_por_supply_seq (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .por_n_o (por_n_o)
  );

endmodule

//--- verif/tb_chip_pad_shell.sv
/*
  Testbench for the pad shell. It plays the core and the chip pins, checks the fake POR
  pattern, then applies a table of pin and core vectors against a model of the pad map.
*/
`timescale 1ns/1ps
`include "pad_shell_config.svh"

module tb_chip_pad_shell;

  localparam int RST_CYCLES  = 3;
  localparam int POR_CYCLES  = 20;
  localparam int NUM_ENTRIES = 24;
  // about four times the scheduled cycles
  localparam int TIMEOUT_CYCLES = 4 * (RST_CYCLES + POR_CYCLES + NUM_ENTRIES) + 12;
  localparam int ATTR_BITS = `NUM_MIO_PADS * `PAD_ATTR_WIDTH;
  localparam logic [31:0] RAND_SEED = 32'hc816fbb9;

  typedef struct packed {
    pad_shell_pkg::gpio_vec_t gpio;
    logic                     uart_rx;
    logic                     spi_sck;
    logic                     spi_csb;
    logic                     spi_sdi;
    logic                     usb_sense;
    logic                     usb_dp;
    logic                     usb_dn;
    pad_shell_pkg::mio_vec_t  mio_out;
    pad_shell_pkg::mio_vec_t  mio_oe;
    logic [ATTR_BITS-1:0]     mio_attr;
    pad_shell_pkg::dio_vec_t  dio_out;
    pad_shell_pkg::dio_vec_t  dio_oe;
  } stim_t;

  typedef struct packed {
    pad_shell_pkg::mio_vec_t  mio_in;
    pad_shell_pkg::dio_vec_t  dio_in;
    pad_shell_pkg::gpio_vec_t gpio_out;
    pad_shell_pkg::gpio_vec_t gpio_en;
    pad_shell_pkg::gpio_vec_t pull_en;
    pad_shell_pkg::gpio_vec_t pull_sel;
    logic                     uart_tx;
    logic                     uart_tx_en;
    logic                     spi_sdo;
    logic                     spi_sdo_en;
    logic                     usb_dp;
    logic                     usb_dp_en;
    logic                     usb_dn;
    logic                     usb_dn_en;
    logic                     usb_d_en;
  } expect_t;

  logic clk_aon;
  logic rst_n_i;
  pad_shell_pkg::gpio_vec_t gpio_p2d_i;
  pad_shell_pkg::gpio_vec_t gpio_d2p_o;
  pad_shell_pkg::gpio_vec_t gpio_en_d2p_o;
  pad_shell_pkg::gpio_vec_t gpio_pull_en_o;
  pad_shell_pkg::gpio_vec_t gpio_pull_select_o;
  logic uart_rx_p2d_i;
  logic uart_tx_d2p_o;
  logic uart_tx_en_d2p_o;
  logic spi_sck_p2d_i;
  logic spi_csb_p2d_i;
  logic spi_sdi_p2d_i;
  logic spi_sdo_d2p_o;
  logic spi_sdo_en_d2p_o;
  logic usb_sense_p2d_i;
  logic usb_dp_p2d_i;
  logic usb_dn_p2d_i;
  logic usb_dp_d2p_o;
  logic usb_dp_en_d2p_o;
  logic usb_dn_d2p_o;
  logic usb_dn_en_d2p_o;
  logic usb_d_en_d2p_o;
  pad_shell_pkg::mio_vec_t mio_out_i;
  pad_shell_pkg::mio_vec_t mio_oe_i;
  logic [ATTR_BITS-1:0] mio_attr_i;
  pad_shell_pkg::mio_vec_t mio_in_o;
  pad_shell_pkg::dio_vec_t dio_out_i;
  pad_shell_pkg::dio_vec_t dio_oe_i;
  pad_shell_pkg::dio_vec_t dio_in_o;
  logic por_n_o;

  stim_t   stim_tab [NUM_ENTRIES];
  expect_t exp_tab  [NUM_ENTRIES];
  int      cycle_count;

  chip_pad_shell DUT (.*);

  ////////////////////////////////////////////////////////////////////////////
  // model of the pad map
  ////////////////////////////////////////////////////////////////////////////

  // MIO pad that carries a gpio bit or -1 where the bit has no pad
  function automatic int pad_of_gpio(input int g);
    if (g <= 6) return 15 + g;
    if (g >= 7 && g <= 13) return 33 + g;
    // Ioc0..2 sit at 22..24 with Ioc5 at 27 and Ioc8 at 30
    if ((g >= 22 && g <= 24) || g == 27 || g == 30) return g;
    return -1;
  endfunction

  function automatic pad_shell_pkg::mio_vec_t mio_from_pins(input stim_t s);
    pad_shell_pkg::mio_vec_t m;
    int p;
    m = '0;
    for (int g = 0; g < 32; g++) begin
      p = pad_of_gpio(g);
      if (p >= 0) m[p] = s.gpio[g];
    end
    m[25] = s.uart_rx;
    m[29] = s.usb_sense;
    return m;
  endfunction

  function automatic pad_shell_pkg::dio_vec_t dio_from_pins(input stim_t s);
    pad_shell_pkg::dio_vec_t d;
    d = '0;
    d[0] = s.usb_dp;
    d[1] = s.usb_dn;
    d[2] = s.spi_sck;
    d[3] = s.spi_csb;
    d[4] = s.spi_sdi;
    return d;
  endfunction

  function automatic pad_shell_pkg::gpio_vec_t gpio_from_pads(input pad_shell_pkg::mio_vec_t m);
    pad_shell_pkg::gpio_vec_t g;
    int p;
    g = '0;
    for (int b = 0; b < 32; b++) begin
      p = pad_of_gpio(b);
      if (p >= 0) g[b] = m[p];
    end
    return g;
  endfunction

  // bit 0 of each attribute word is pull_en and bit 1 is pull_select
  function automatic pad_shell_pkg::mio_vec_t attr_plane(input logic [ATTR_BITS-1:0] attr,
                                                         input int sel);
    pad_shell_pkg::mio_vec_t plane;
    for (int p = 0; p < `NUM_MIO_PADS; p++) begin
      plane[p] = attr[2 * p + sel];
    end
    return plane;
  endfunction

  function automatic expect_t derive_expected(input stim_t s);
    expect_t e;
    e.mio_in     = mio_from_pins(s);
    e.dio_in     = dio_from_pins(s);
    e.gpio_out   = gpio_from_pads(s.mio_out);
    e.gpio_en    = gpio_from_pads(s.mio_oe);
    e.pull_en    = gpio_from_pads(attr_plane(s.mio_attr, 0));
    e.pull_sel   = gpio_from_pads(attr_plane(s.mio_attr, 1));
    e.uart_tx    = s.mio_out[26];
    e.uart_tx_en = s.mio_oe[26];
    e.spi_sdo    = s.dio_out[5];
    e.spi_sdo_en = s.dio_oe[5];
    e.usb_dp     = s.dio_out[0];
    e.usb_dp_en  = s.dio_oe[0];
    e.usb_dn     = s.dio_out[1];
    e.usb_dn_en  = s.dio_oe[1];
    e.usb_d_en   = s.dio_oe[0];
    return e;
  endfunction

  // low 0..3 then high 4..7 then low 8..11 then high from 12 up to the stop at 15
  function automatic logic por_pattern(input int k);
    int c;
    c = (k > 15) ? 15 : k;
    return ((c >= 4 && c < 8) || c >= 12);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    stim_t s;
    logic [63:0] r64;
    logic [95:0] r96;
    stim_tab[0] = '0;
    stim_tab[1] = '1;
    // stride patterns so neighbouring pads differ
    s = '0;
    s.gpio = 32'h8421_8421;
    for (int p = 0; p < `NUM_MIO_PADS; p++) begin
      s.mio_out[p] = (p % 3 == 0);
      s.mio_oe[p]  = (p % 3 == 1);
      s.mio_attr[2 * p +: 2] = 2'(p % 3);
    end
    s.dio_out   = 16'h1111;
    s.dio_oe    = 16'h2222;
    s.uart_rx   = 1'b1;
    s.spi_csb   = 1'b1;
    s.usb_sense = 1'b1;
    s.usb_dn    = 1'b1;
    stim_tab[2] = s;
    // inverse of entry 2 with pull attributes alternating 01 and 10
    s = stim_t'(~stim_tab[2]);
    for (int p = 0; p < `NUM_MIO_PADS; p++) begin
      s.mio_attr[2 * p +: 2] = p[0] ? 2'b10 : 2'b01;
    end
    stim_tab[3] = s;
    for (int i = 4; i < NUM_ENTRIES; i++) begin
      s.gpio = $urandom();
      r64 = {$urandom(), $urandom()};
      s.mio_out = r64[46:0];
      r64 = {$urandom(), $urandom()};
      s.mio_oe = r64[46:0];
      r96 = {$urandom(), $urandom(), $urandom()};
      s.mio_attr = r96[ATTR_BITS-1:0];
      r64 = {$urandom(), $urandom()};
      s.dio_out   = r64[15:0];
      s.dio_oe    = r64[31:16];
      s.uart_rx   = r64[32];
      s.spi_sck   = r64[33];
      s.spi_csb   = r64[34];
      s.spi_sdi   = r64[35];
      s.usb_sense = r64[36];
      s.usb_dp    = r64[37];
      s.usb_dn    = r64[38];
      stim_tab[i] = s;
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      exp_tab[i] = derive_expected(stim_tab[i]);
    end
  endtask

  task automatic apply_entry(input stim_t s);
    gpio_p2d_i      = s.gpio;
    uart_rx_p2d_i   = s.uart_rx;
    spi_sck_p2d_i   = s.spi_sck;
    spi_csb_p2d_i   = s.spi_csb;
    spi_sdi_p2d_i   = s.spi_sdi;
    usb_sense_p2d_i = s.usb_sense;
    usb_dp_p2d_i    = s.usb_dp;
    usb_dn_p2d_i    = s.usb_dn;
    mio_out_i       = s.mio_out;
    mio_oe_i        = s.mio_oe;
    mio_attr_i      = s.mio_attr;
    dio_out_i       = s.dio_out;
    dio_oe_i        = s.dio_oe;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
               $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first wrong value");
    end
  endtask

  task automatic check_entry(input expect_t e);
    check_value("mio_in_o", 64'(mio_in_o), 64'(e.mio_in));
    check_value("dio_in_o", 64'(dio_in_o), 64'(e.dio_in));
    check_value("gpio_d2p_o", 64'(gpio_d2p_o), 64'(e.gpio_out));
    check_value("gpio_en_d2p_o", 64'(gpio_en_d2p_o), 64'(e.gpio_en));
    check_value("gpio_pull_en_o", 64'(gpio_pull_en_o), 64'(e.pull_en));
    check_value("gpio_pull_select_o", 64'(gpio_pull_select_o), 64'(e.pull_sel));
    check_value("uart_tx_d2p_o", 64'(uart_tx_d2p_o), 64'(e.uart_tx));
    check_value("uart_tx_en_d2p_o", 64'(uart_tx_en_d2p_o), 64'(e.uart_tx_en));
    check_value("spi_sdo_d2p_o", 64'(spi_sdo_d2p_o), 64'(e.spi_sdo));
    check_value("spi_sdo_en_d2p_o", 64'(spi_sdo_en_d2p_o), 64'(e.spi_sdo_en));
    check_value("usb_dp_d2p_o", 64'(usb_dp_d2p_o), 64'(e.usb_dp));
    check_value("usb_dp_en_d2p_o", 64'(usb_dp_en_d2p_o), 64'(e.usb_dp_en));
    check_value("usb_dn_d2p_o", 64'(usb_dn_d2p_o), 64'(e.usb_dn));
    check_value("usb_dn_en_d2p_o", 64'(usb_dn_en_d2p_o), 64'(e.usb_dn_en));
    check_value("usb_d_en_d2p_o", 64'(usb_d_en_d2p_o), 64'(e.usb_d_en));
    // counter is saturated by now
    check_value("por_n_o", 64'(por_n_o), 64'(1'b1));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, timeout and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  always @(posedge clk_aon) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  initial begin
    int unsigned seed_sink;
    cycle_count = 0;
    rst_n_i = 1'b0;
    apply_entry('0);
    seed_sink = $urandom(RAND_SEED);
    build_table();

    repeat (RST_CYCLES) @(posedge clk_aon);
    @(negedge clk_aon);
    rst_n_i = 1'b1;

    // por follows the count reached after k edges
    for (int k = 0; k < POR_CYCLES; k++) begin
      if (k > 0) @(negedge clk_aon);
      #1;
      check_value("por_n_o", 64'(por_n_o), 64'(por_pattern(k)));
    end

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(negedge clk_aon);
      apply_entry(stim_tab[i]);
      #1;
      check_entry(exp_tab[i]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/pad_shell_pkg.sv
verilog/pad_core_if.sv
verilog/pad_in_map.sv
verilog/pad_out_map.sv
verilog/por_supply_seq.sv
verilog/chip_pad_shell.sv
verif/tb_chip_pad_shell.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the pad shell testbench with Verilator and run it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f filelist.f \
  --top-module tb_chip_pad_shell

# the log decides the result, so a fatal exit of the binary is not fatal here
./obj_dir/Vtb_chip_pad_shell > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  echo "run_sim: passed"
else
  echo "run_sim: failed, see $LOG"
  exit 1
fi
